/* Makefile */
TOP := tb_mem_if

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f list.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

/* dv/tb_clkgen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock source, free running from time zero
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter int PERIOD = 100
) (
  output logic clk
);

  // Low first, rising edge at half period
  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

/* dv/tb_mem_if.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the memory front end
// Wishbone memory model, random fetch and load/store traffic, reference checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mem_if;

  import biu_pkg::*;

  localparam int          MEM_WORDS  = 1024;
  localparam logic [31:0] FILL_KEY   = 32'h5A3C_96E1;
  localparam logic [31:0] PC_LIMIT   = 32'h0000_0800;
  localparam logic [31:0] LS_BASE    = 32'h0000_0E00;
  localparam logic [31:0] ERR_BASE   = 32'h0000_4000;
  localparam logic [31:0] IO_BASE    = 32'h8000_0000;
  localparam int          NUM_CYCLES = 5000;
  localparam int          SETTLE     = 40;
  localparam int          LS_LIMIT   = 64;
  localparam int          IDLE_LIMIT = 300;

  logic        clk;
  logic        rstn;
  logic [31:0] if_nxt_pc;
  logic        if_stall;
  logic        if_flush;
  logic        if_stall_nxt_pc;
  logic [31:0] if_parcel_pc;
  logic [31:0] if_parcel;
  logic        if_parcel_valid;
  logic        if_parcel_misaligned;
  logic        ls_req;
  logic        ls_we;
  logic [31:0] ls_adr;
  logic [31:0] ls_wdata;
  logic        ls_busy;
  logic        ls_done;
  logic        ls_err;
  logic [31:0] ls_rdata;
  prv_t        st_prv;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [31:0] wb_adr;
  logic [31:0] wb_dat_o;
  logic [3:0]  wb_sel;
  logic [31:0] wb_dat_i;
  logic        wb_ack;
  logic        wb_err;
  logic        io_access;
  prv_t        bus_prv;

  tb_clkgen #(.PERIOD(100)) u_clkgen (.clk(clk));

  mem_if_top #(
    .XLEN        (32),
    .PLEN        (32),
    .PARCEL_SIZE (32)
  ) DUT (
    .clk (clk), .rstn (rstn),
    .if_nxt_pc (if_nxt_pc), .if_stall (if_stall), .if_flush (if_flush),
    .if_stall_nxt_pc (if_stall_nxt_pc), .if_parcel_pc (if_parcel_pc),
    .if_parcel (if_parcel), .if_parcel_valid (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .ls_req (ls_req), .ls_we (ls_we), .ls_adr (ls_adr), .ls_wdata (ls_wdata),
    .ls_busy (ls_busy), .ls_done (ls_done), .ls_err (ls_err), .ls_rdata (ls_rdata),
    .st_prv (st_prv),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_o (wb_dat_o), .wb_sel (wb_sel), .wb_dat_i (wb_dat_i),
    .wb_ack (wb_ack), .wb_err (wb_err), .io_access (io_access), .bus_prv (bus_prv)
  );

  // Slave storage and the expected contents
  logic [31:0] bus_mem [MEM_WORDS];
  logic [31:0] ref_mem [MEM_WORDS];
  // PCs accepted by the bus, oldest first
  logic [31:0] exp_pc_q [$];

  integer      seed = 69735;
  int          err_count;
  int          n_checks;
  int          n_timeouts;
  bit          timed_out;
  // Slave wait states
  bit          slave_busy;
  int          slave_wait;
  // Previous bus sample
  bit          bus_open;
  logic [31:0] bus_adr;
  logic        bus_we;
  // Expected attributes of the open bus cycle
  logic        bus_exp_io;
  prv_t        bus_exp_prv;
  // PC source and fetch progress
  bit          pc_taken;
  logic [31:0] taken_pc;
  prv_t        taken_prv;
  int          idle_age;
  // Outstanding load/store
  bit          ls_open;
  bit          ls_reload;
  logic        ls_exp_we;
  logic [31:0] ls_exp_adr;
  logic [31:0] ls_exp_data;
  prv_t        ls_exp_prv;
  int          ls_age;
  bit          last_store;
  logic [31:0] last_store_adr;
  // Stimulus reach
  int          n_parcels, n_flush, n_misaligned, n_ls_err, n_reload, n_io;

  function automatic int unsigned pick(input int unsigned n);
    return {$random(seed)} % n;
  endfunction

  // Each word is its byte address XOR a key
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return (idx * 4) ^ FILL_KEY;
  endfunction

  // IO region aliases onto the memory, the rest of the space is absent
  function automatic bit in_memory(input logic [31:0] adr);
    return adr[31] || (adr < MEM_WORDS * 4);
  endfunction

  function automatic int word_idx(input logic [31:0] adr);
    return int'(adr[11:2]);
  endfunction

  task automatic verify(input bit ok, input string msg);
    n_checks++;
    assert (ok) else begin
      err_count++;
      $display("ERR %0t: %s", $time, msg);
    end
  endtask

  task automatic require(input bit ok, input string msg);
    n_checks++;
    assert (ok) else begin
      err_count++;
      $display("Random stimulus never reached this case: %s", msg);
    end
  endtask

  task automatic check_quiet();
    verify(!wb_cyc && !if_parcel_valid && !ls_done && !ls_busy,
           $sformatf("outputs not idle around reset, cyc %0b valid %0b done %0b busy %0b",
                     wb_cyc, if_parcel_valid, ls_done, ls_busy));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, all on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  // Wishbone slave, 0 to 3 wait states per cycle
  task automatic drive_bus_slave();
    wb_ack = 1'b0;
    wb_err = 1'b0;
    if (wb_cyc) begin
      if (!slave_busy) begin
        slave_busy = 1'b1;
        slave_wait = pick(4);
      end
      if (slave_wait == 0) begin
        slave_busy = 1'b0;
        if (in_memory(wb_adr)) begin
          wb_ack   = 1'b1;
          wb_dat_i = bus_mem[word_idx(wb_adr)];
          if (wb_we) begin
            bus_mem[word_idx(wb_adr)] = wb_dat_o;
          end
        end else begin
          wb_err = 1'b1;
        end
      end else begin
        slave_wait--;
      end
    end
  endtask

  // PC source, step on acceptance, jump on flush
  task automatic drive_fetch();
    if (pc_taken) begin
      if_nxt_pc = if_nxt_pc + 4;
    end
    if_flush = 1'b0;
    if (pick(100) < 3 || if_nxt_pc >= PC_LIMIT) begin
      if_flush  = 1'b1;
      if_nxt_pc = pick(PC_LIMIT / 4 - 4) * 4;
      // Occasional odd target
      if (pick(8) == 0) begin
        if_nxt_pc = if_nxt_pc + 1 + pick(3);
      end
      n_flush++;
    end
    if_stall = (pick(100) < 20);
    // Privilege level moves at random
    case (pick(3))
      0:       st_prv = USER;
      1:       st_prv = SUPER;
      default: st_prv = MACHINE;
    endcase
  endtask

  // One access at a time in a 16-word window
  task automatic drive_lsu(input bit allow);
    int unsigned kind;
    ls_req = 1'b0;
    if (allow && !ls_busy && !ls_open && pick(100) < 15) begin
      kind      = pick(16);
      ls_reload = last_store && (pick(2) == 0);
      if (ls_reload) begin
        ls_we  = 1'b0;
        ls_adr = last_store_adr;
      end else begin
        ls_we  = (pick(2) == 1);
        ls_adr = LS_BASE + pick(16) * 4;
        if (kind == 0) begin
          ls_adr = ERR_BASE + pick(16) * 4;
        end else if (kind == 1) begin
          ls_adr = ls_adr | IO_BASE;
        end
      end
      ls_wdata       = $random(seed);
      ls_req         = 1'b1;
      ls_open        = 1'b1;
      ls_age         = 0;
      ls_exp_adr     = ls_adr;
      ls_exp_we      = ls_we;
      ls_exp_data    = ls_wdata;
      ls_exp_prv     = st_prv;
      last_store     = ls_we && in_memory(ls_adr);
      last_store_adr = ls_adr;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks, sampled shortly before the rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic sample_and_check();
    logic [31:0] head_pc;
    int          idx;
    bit          exp_err;
    logic [31:0] exp_adr;
    logic        exp_we;
    prv_t        exp_prv;
    // Classic cycle held steady until the slave ends it
    verify(wb_stb == wb_cyc, $sformatf("wb_stb %0b differs from wb_cyc %0b", wb_stb, wb_cyc));
    if (bus_open) begin
      verify(wb_cyc && wb_adr == bus_adr && wb_we == bus_we,
             $sformatf("bus cycle at %h dropped or moved before ack, cyc %0b adr %h",
                       bus_adr, wb_cyc, wb_adr));
    end
    // New cycle carries the request granted at the last edge
    if (wb_cyc && !bus_open) begin
      if (pc_taken) begin
        exp_adr = taken_pc;
        exp_we  = 1'b0;
        exp_prv = taken_prv;
      end else begin
        verify(ls_open, "bus cycle started with no request granted");
        exp_adr = ls_exp_adr;
        exp_we  = ls_exp_we;
        exp_prv = ls_exp_prv;
      end
      verify(wb_adr == exp_adr && wb_we == exp_we,
             $sformatf("bus cycle adr %h we %0b, expected adr %h we %0b",
                       wb_adr, wb_we, exp_adr, exp_we));
      if (exp_we) begin
        verify(wb_dat_o == ls_exp_data,
               $sformatf("store data %h on the bus, expected %h", wb_dat_o, ls_exp_data));
      end
      bus_exp_io  = exp_adr[31];
      bus_exp_prv = exp_prv;
      if (exp_adr[31]) n_io++;
    end
    if (wb_cyc) begin
      verify(wb_sel == 4'hF, $sformatf("wb_sel %h, expected all byte lanes", wb_sel));
      verify(io_access == bus_exp_io,
             $sformatf("io_access %0b for address %h", io_access, wb_adr));
      verify(bus_prv == bus_exp_prv,
             $sformatf("bus_prv %0d, expected %0d", bus_prv, bus_exp_prv));
    end
    bus_open = wb_cyc && !wb_ack && !wb_err;
    bus_adr  = wb_adr;
    bus_we   = wb_we;

    // Fetch, parcels leave in PC order
    if (if_parcel_valid) begin
      idle_age = 0;
      n_parcels++;
      verify(!if_stall, "parcel valid while if_stall is high");
      if (exp_pc_q.size() == 0) begin
        verify(1'b0, $sformatf("parcel at %h with no fetch outstanding", if_parcel_pc));
      end else begin
        head_pc = exp_pc_q.pop_front();
        verify(if_parcel_pc == head_pc,
               $sformatf("parcel pc %h, expected %h", if_parcel_pc, head_pc));
        verify(if_parcel == ref_mem[word_idx(head_pc)],
               $sformatf("parcel %h at %h, expected %h", if_parcel, head_pc,
                         ref_mem[word_idx(head_pc)]));
        verify(if_parcel_misaligned == (head_pc[1:0] != 2'b00),
               $sformatf("misaligned flag %0b at %h", if_parcel_misaligned, head_pc));
        if (head_pc[1:0] != 2'b00) n_misaligned++;
      end
    end else begin
      idle_age++;
    end
    // Flush drops everything in flight
    if (if_flush) begin
      exp_pc_q.delete();
    end
    pc_taken = !if_flush && !if_stall_nxt_pc;
    if (pc_taken) begin
      exp_pc_q.push_back(if_nxt_pc);
      taken_pc  = if_nxt_pc;
      taken_prv = st_prv;
    end

    // Load/store against the reference memory
    if (ls_open && ls_done) begin
      idx     = word_idx(ls_exp_adr);
      exp_err = !in_memory(ls_exp_adr);
      verify(ls_err == exp_err,
             $sformatf("ls_err %0b at %h, expected %0b", ls_err, ls_exp_adr, exp_err));
      if (exp_err) begin
        n_ls_err++;
      end else if (ls_exp_we) begin
        ref_mem[idx] = ls_exp_data;
      end else begin
        verify(ls_rdata == ref_mem[idx],
               $sformatf("load %h from %h, expected %h", ls_rdata, ls_exp_adr, ref_mem[idx]));
        if (ls_reload) n_reload++;
      end
      ls_open = 1'b0;
    end else if (ls_open) begin
      verify(ls_busy || ls_req, "ls_busy low while an access is outstanding");
      ls_age++;
    end else begin
      verify(!ls_done, "ls_done without an outstanding access");
    end

    if (ls_age > LS_LIMIT && ls_open) begin
      timed_out = 1'b1;
      n_timeouts++;
      $display("Timeout at %0t: access to %h never completed", $time, ls_exp_adr);
    end
    if (idle_age > IDLE_LIMIT) begin
      timed_out = 1'b1;
      n_timeouts++;
      $display("Timeout at %0t: fetch delivered no parcel for too long", $time);
    end
  endtask

  task automatic run_cycle(input bit allow_ls);
    @(negedge clk);
    drive_bus_slave();
    drive_fetch();
    drive_lsu(allow_ls);
    #(SETTLE);
    sample_and_check();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int cycle;
    int drain;
    rstn      = 1'b0;
    if_nxt_pc = '0;
    if_stall  = 1'b0;
    if_flush  = 1'b0;
    ls_req    = 1'b0;
    ls_we     = 1'b0;
    ls_adr    = '0;
    ls_wdata  = '0;
    st_prv    = MACHINE;
    wb_ack    = 1'b0;
    wb_err    = 1'b0;
    wb_dat_i  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      bus_mem[i] = fill_word(i);
      ref_mem[i] = fill_word(i);
    end

    // Three rising edges in reset, outputs quiet throughout
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_quiet();
    end
    rstn = 1'b1;
    #(SETTLE);
    check_quiet();

    cycle = 0;
    while (cycle < NUM_CYCLES && !timed_out) begin
      run_cycle(1'b1);
      cycle++;
    end

    // No new accesses, let the last one finish
    drain = 0;
    while (ls_open && !timed_out) begin
      run_cycle(1'b0);
      drain++;
      if (drain > LS_LIMIT) begin
        timed_out = 1'b1;
        n_timeouts++;
        $display("Timeout: last load/store never finished while draining");
      end
    end

    if (!timed_out) begin
      require(n_parcels > 100, "too few parcels");
      require(n_flush > 0, "flush");
      require(n_misaligned > 0, "misaligned parcel");
      require(n_ls_err > 0, "load/store bus error");
      require(n_reload > 0, "load after store to the same word");
      require(n_io > 0, "IO region access");
    end

    $display("Checks %0d, errors %0d, timeouts %0d, parcels %0d",
             n_checks, err_count, n_timeouts, n_parcels);
    if (err_count == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/biu_pkg.sv
logic/ifetch_nocache.sv
logic/lsu_nocache.sv
logic/biu_wb_arbiter.sv
logic/mem_if_top.sv
dv/tb_clkgen.sv
dv/tb_mem_if.sv

/* logic/biu_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Bus interface encodings shared by fetch, load/store and arbiter
// Transfer size, burst type, privilege level and the IO region bit
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package biu_pkg;

  // Transfer size, only WORD is issued by this front end
  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010,
    DWORD = 3'b011
  } biu_size_t;

  // Burst type, AHB style
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } biu_type_t;

  // Privilege level, mstatus style encoding
  typedef enum logic [1:0] {
    USER    = 2'b00,
    SUPER   = 2'b01,
    MACHINE = 2'b11
  } prv_t;

  // Address bit set marks the non-cacheable IO region
  // Bit clear means cacheable instruction/data memory
  localparam int IO_REGION_BIT = 31;

endpackage

`default_nettype wire

/* logic/biu_wb_arbiter.sv */
////////////////////////////////////////////////////////////////////////////
// Two-requester bus arbiter, load/store first
// Wishbone classic master, single cycles only
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module biu_wb_arbiter #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic               clk,
  input  logic               rstn,

  // Fetch requester
  input  logic               if_stb,
  input  logic [PLEN-1:0]    if_adr,
  input  logic               if_we,
  input  logic [XLEN-1:0]    if_dat_w,
  input  logic [XLEN/8-1:0]  if_sel,
  input  biu_pkg::biu_size_t if_size,
  input  biu_pkg::biu_type_t if_type,
  input  biu_pkg::prv_t      if_prv,
  output logic               if_stb_ack,
  output logic               if_ack,
  output logic               if_err,
  output logic [XLEN-1:0]    if_dat_r,
  output logic [PLEN-1:0]    if_adr_r,

  // Load/store requester
  input  logic               ls_stb,
  input  logic [PLEN-1:0]    ls_adr,
  input  logic               ls_we,
  input  logic [XLEN-1:0]    ls_dat_w,
  input  logic [XLEN/8-1:0]  ls_sel,
  input  biu_pkg::biu_size_t ls_size,
  input  biu_pkg::biu_type_t ls_type,
  input  biu_pkg::prv_t      ls_prv,
  output logic               ls_stb_ack,
  output logic               ls_ack,
  output logic               ls_err,
  output logic [XLEN-1:0]    ls_dat_r,

  // Wishbone master
  output logic               wb_cyc,
  output logic               wb_stb,
  output logic               wb_we,
  output logic [PLEN-1:0]    wb_adr,
  output logic [XLEN-1:0]    wb_dat_o,
  output logic [XLEN/8-1:0]  wb_sel,
  input  logic [XLEN-1:0]    wb_dat_i,
  input  logic               wb_ack,
  input  logic               wb_err,
  output logic               io_access,
  output biu_pkg::prv_t      bus_prv
);

  import biu_pkg::*;

  typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;

  arb_state_t        state;
  logic              owner_ls;
  logic              idle;
  logic [PLEN-1:0]   adr_q;
  logic              we_q;
  logic [XLEN-1:0]   dat_q;
  logic [XLEN/8-1:0] sel_q;
  prv_t              prv_q;

  // Grant in the same cycle, load/store wins a tie
  assign idle       = (state == ARB_IDLE);
  assign ls_stb_ack = idle & ls_stb;
  assign if_stb_ack = idle & if_stb & ~ls_stb;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state    <= ARB_IDLE;
      owner_ls <= 1'b0;
    end else if (idle) begin
      if (if_stb || ls_stb) begin
        state    <= ARB_BUSY;
        owner_ls <= ls_stb;
      end
    end else if (wb_ack || wb_err) begin
      state <= ARB_IDLE;
    end
  end

  // Winning request held for the whole bus cycle
  always_ff @(posedge clk) begin
    if (ls_stb_ack) begin
      adr_q <= ls_adr;
      we_q  <= ls_we;
      dat_q <= ls_dat_w;
      sel_q <= ls_sel;
      prv_q <= ls_prv;
    end else if (if_stb_ack) begin
      adr_q <= if_adr;
      we_q  <= if_we;
      dat_q <= if_dat_w;
      sel_q <= if_sel;
      prv_q <= if_prv;
    end
  end

  // Bus side
  assign wb_cyc    = ~idle;
  assign wb_stb    = ~idle;
  assign wb_we     = ~idle & we_q;
  assign wb_adr    = adr_q;
  assign wb_dat_o  = dat_q;
  assign wb_sel    = sel_q;
  assign io_access = adr_q[IO_REGION_BIT];
  assign bus_prv   = prv_q;

  // Responses steered to the owner
  assign if_ack    = ~idle & ~owner_ls & wb_ack;
  assign if_err    = ~idle & ~owner_ls & wb_err;
  assign ls_ack    = ~idle & owner_ls & wb_ack;
  assign ls_err    = ~idle & owner_ls & wb_err;
  assign if_dat_r  = wb_dat_i;
  assign ls_dat_r  = wb_dat_i;
  assign if_adr_r  = adr_q;

  // Classic cycle held with stable request until the slave ends it
  assert property (@(posedge clk) disable iff (!rstn)
    wb_cyc && !(wb_ack || wb_err) |=>
      wb_cyc && wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o));

  // Only one requester granted, and its request drives the next bus cycle
  assert property (@(posedge clk) disable iff (!rstn)
    ls_stb_ack |=> wb_cyc && owner_ls && wb_adr == $past(ls_adr) && wb_we == $past(ls_we));

  assert property (@(posedge clk) disable iff (!rstn)
    if_stb_ack |=> wb_cyc && !owner_ls && wb_adr == $past(if_adr) && !wb_we);

  // Requesters issue single word transfers only
  assert property (@(posedge clk) disable iff (!rstn)
    if_stb_ack |-> if_size == WORD && if_type == SINGLE);

  assert property (@(posedge clk) disable iff (!rstn)
    ls_stb_ack |-> ls_size == WORD && ls_type == SINGLE);

endmodule

`default_nettype wire

/* logic/ifetch_nocache.sv */
////////////////////////////////////////////////////////////////////////////
// Instruction fetch without cache
// Issues single reads, three-entry return FIFO, flush and stall handling
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ifetch_nocache #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int PARCEL_SIZE = 32
) (
  input  logic                   clk,
  input  logic                   rstn,

  // CPU side
  input  logic [XLEN-1:0]        if_nxt_pc,
  input  logic                   if_stall,
  input  logic                   if_flush,
  output logic                   if_stall_nxt_pc,
  output logic [XLEN-1:0]        if_parcel_pc,
  output logic [PARCEL_SIZE-1:0] if_parcel,
  output logic                   if_parcel_valid,
  output logic                   if_parcel_misaligned,
  input  biu_pkg::prv_t          st_prv,

  // Requester port to the arbiter
  output logic                   biu_stb,
  input  logic                   biu_stb_ack,
  output logic [PLEN-1:0]        biu_adri,
  input  logic [PLEN-1:0]        biu_adro,
  input  logic [XLEN-1:0]        biu_do,
  input  logic                   biu_ack,
  input  logic                   biu_err,
  output logic                   biu_is_cacheable,
  output biu_pkg::prv_t          biu_prv
);

  import biu_pkg::*;

  logic            fetch_rdy;
  logic            flush_dly;
  logic            pend;
  logic            stale;
  logic            push;
  logic            pop;
  logic [2:0]      fifo_valid;
  logic [2:0]      v_shift;
  logic [2:0]      wr_sel;
  logic [XLEN-1:0] fifo_dat [3];
  logic [PLEN-1:0] fifo_adr [3];

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Ready one cycle out of reset, flush seen for two cycles
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fetch_rdy <= 1'b0;
      flush_dly <= 1'b0;
    end else begin
      fetch_rdy <= 1'b1;
      flush_dly <= if_flush;
    end
  end

  // Issue only with room for the returning word
  assign biu_stb          = fetch_rdy & ~if_flush & ~if_stall & ~fifo_valid[1];
  assign biu_adri         = if_nxt_pc[PLEN-1:0];
  assign biu_is_cacheable = ~if_nxt_pc[IO_REGION_BIT];
  assign biu_prv          = st_prv;

  // PC source holds while the request waits or the FIFO fills
  assign if_stall_nxt_pc  = ~biu_stb_ack | fifo_valid[1];

  // One read in flight at most
  // Stale marks a read that was issued before a flush
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pend  <= 1'b0;
      stale <= 1'b0;
    end else if (biu_ack || biu_err) begin
      pend  <= 1'b0;
      stale <= 1'b0;
    end else begin
      if (biu_stb_ack) begin
        pend <= 1'b1;
      end
      if (if_flush && pend) begin
        stale <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Return FIFO
  ////////////////////////////////////////////////////////////////////////////

  // Fetch errors are dropped like flushed words
  assign push    = biu_ack & pend & ~stale & ~if_flush;
  assign pop     = if_parcel_valid;

  // Valid bits after the pop, then first free slot
  assign v_shift = pop ? {1'b0, fifo_valid[2:1]} : fifo_valid;
  assign wr_sel  = ~v_shift & {v_shift[1:0], 1'b1};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      fifo_valid <= 3'b000;
    end else if (if_flush) begin
      fifo_valid <= 3'b000;
    end else begin
      fifo_valid <= v_shift | (push ? wr_sel : 3'b000);
    end
  end

  // Shift down on pop, new word lands in the free slot
  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (push && wr_sel[i]) begin
        fifo_dat[i] <= biu_do;
        fifo_adr[i] <= biu_adro;
      end else if (pop) begin
        fifo_dat[i] <= fifo_dat[i+1];
        fifo_adr[i] <= fifo_adr[i+1];
      end
    end
    if (push && wr_sel[2]) begin
      fifo_dat[2] <= biu_do;
      fifo_adr[2] <= biu_adro;
    end
  end

  // To CPU, head of FIFO
  assign if_parcel_valid      = fifo_valid[0] & ~(if_flush | flush_dly) & ~if_stall;
  assign if_parcel_pc         = XLEN'(fifo_adr[0]);
  assign if_parcel            = fifo_dat[0][PARCEL_SIZE-1:0];
  // No 16-bit parcels, any low bit set is misaligned
  assign if_parcel_misaligned = |fifo_adr[0][1:0];

  // Entry 1 gates issue and only one read is in flight, so entry 2 stays spare
  assert property (@(posedge clk) disable iff (!rstn) push |-> !fifo_valid[2]);

endmodule

`default_nettype wire

/* logic/lsu_nocache.sv */
////////////////////////////////////////////////////////////////////////////
// Load/store unit without cache, one access outstanding
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_nocache #(
  parameter int XLEN = 32,
  parameter int PLEN = 32
) (
  input  logic            clk,
  input  logic            rstn,

  // CPU side
  input  logic            ls_req,
  input  logic            ls_we,
  input  logic [PLEN-1:0] ls_adr,
  input  logic [XLEN-1:0] ls_wdata,
  input  biu_pkg::prv_t   st_prv,
  output logic            ls_busy,
  output logic            ls_done,
  output logic            ls_err,
  output logic [XLEN-1:0] ls_rdata,

  // Requester port to the arbiter
  output logic            biu_stb,
  input  logic            biu_stb_ack,
  output logic [PLEN-1:0] biu_adri,
  output logic            biu_we,
  output logic [XLEN-1:0] biu_di,
  output logic            biu_is_cacheable,
  output biu_pkg::prv_t   biu_prv,
  input  logic [XLEN-1:0] biu_do,
  input  logic            biu_ack,
  input  logic            biu_err
);

  import biu_pkg::*;

  typedef enum logic [1:0] {LS_IDLE, LS_REQ, LS_WAIT} ls_state_t;

  ls_state_t       state;
  logic [PLEN-1:0] adr_q;
  logic            we_q;
  logic [XLEN-1:0] wdata_q;
  prv_t            prv_q;

  // Idle, then stb held until taken, then wait for the bus cycle
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state   <= LS_IDLE;
      ls_done <= 1'b0;
      ls_err  <= 1'b0;
    end else begin
      ls_done <= 1'b0;
      case (state)
        LS_IDLE: if (ls_req) state <= LS_REQ;
        LS_REQ:  if (biu_stb_ack) state <= LS_WAIT;
        LS_WAIT: begin
          if (biu_ack || biu_err) begin
            state   <= LS_IDLE;
            ls_done <= 1'b1;
            ls_err  <= biu_err;
          end
        end
        default: state <= LS_IDLE;
      endcase
    end
  end

  // Request captured at acceptance, read word at ack
  always_ff @(posedge clk) begin
    if (state == LS_IDLE && ls_req) begin
      adr_q   <= ls_adr;
      we_q    <= ls_we;
      wdata_q <= ls_wdata;
      prv_q   <= st_prv;
    end
    if (state == LS_WAIT && biu_ack) begin
      ls_rdata <= biu_do;
    end
  end

  assign ls_busy          = (state != LS_IDLE);
  assign biu_stb          = (state == LS_REQ);
  assign biu_adri         = adr_q;
  assign biu_we           = we_q;
  assign biu_di           = wdata_q;
  assign biu_is_cacheable = ~adr_q[IO_REGION_BIT];
  assign biu_prv          = prv_q;

  // CPU must wait for done before the next access
  assert property (@(posedge clk) disable iff (!rstn) ls_busy |-> !ls_req);

endmodule

`default_nettype wire

/* logic/mem_if_top.sv */
////////////////////////////////////////////////////////////////////////////
// Memory-side front end, fetch and load/store onto one Wishbone port
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_if_top #(
  parameter int XLEN        = 32,
  parameter int PLEN        = 32,
  parameter int PARCEL_SIZE = 32
) (
  input  logic                   clk,
  input  logic                   rstn,

  // Fetch, CPU side
  input  logic [XLEN-1:0]        if_nxt_pc,
  input  logic                   if_stall,
  input  logic                   if_flush,
  output logic                   if_stall_nxt_pc,
  output logic [XLEN-1:0]        if_parcel_pc,
  output logic [PARCEL_SIZE-1:0] if_parcel,
  output logic                   if_parcel_valid,
  output logic                   if_parcel_misaligned,

  // Load/store, CPU side
  input  logic                   ls_req,
  input  logic                   ls_we,
  input  logic [PLEN-1:0]        ls_adr,
  input  logic [XLEN-1:0]        ls_wdata,
  output logic                   ls_busy,
  output logic                   ls_done,
  output logic                   ls_err,
  output logic [XLEN-1:0]        ls_rdata,

  input  biu_pkg::prv_t          st_prv,

  // Wishbone master
  output logic                   wb_cyc,
  output logic                   wb_stb,
  output logic                   wb_we,
  output logic [PLEN-1:0]        wb_adr,
  output logic [XLEN-1:0]        wb_dat_o,
  output logic [XLEN/8-1:0]      wb_sel,
  input  logic [XLEN-1:0]        wb_dat_i,
  input  logic                   wb_ack,
  input  logic                   wb_err,
  output logic                   io_access,
  output biu_pkg::prv_t          bus_prv
);

  import biu_pkg::*;

  // Fetch to arbiter
  logic            fe_stb;
  logic            fe_stb_ack;
  logic [PLEN-1:0] fe_adr;
  prv_t            fe_prv;
  logic            fe_ack;
  logic            fe_err;
  logic [XLEN-1:0] fe_dat_r;
  logic [PLEN-1:0] fe_adr_r;

  // Load/store to arbiter
  logic            ld_stb;
  logic            ld_stb_ack;
  logic [PLEN-1:0] ld_adr;
  logic            ld_we;
  logic [XLEN-1:0] ld_dat_w;
  prv_t            ld_prv;
  logic            ld_ack;
  logic            ld_err;
  logic [XLEN-1:0] ld_dat_r;

  ifetch_nocache #(
    .XLEN        (XLEN),
    .PLEN        (PLEN),
    .PARCEL_SIZE (PARCEL_SIZE)
  ) u_ifetch (
    .clk                  (clk),
    .rstn                 (rstn),
    .if_nxt_pc            (if_nxt_pc),
    .if_stall             (if_stall),
    .if_flush             (if_flush),
    .if_stall_nxt_pc      (if_stall_nxt_pc),
    .if_parcel_pc         (if_parcel_pc),
    .if_parcel            (if_parcel),
    .if_parcel_valid      (if_parcel_valid),
    .if_parcel_misaligned (if_parcel_misaligned),
    .st_prv               (st_prv),
    .biu_stb              (fe_stb),
    .biu_stb_ack          (fe_stb_ack),
    .biu_adri             (fe_adr),
    .biu_adro             (fe_adr_r),
    .biu_do               (fe_dat_r),
    .biu_ack              (fe_ack),
    .biu_err              (fe_err),
    .biu_is_cacheable     (),
    .biu_prv              (fe_prv)
  );

  lsu_nocache #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) u_lsu (
    .clk              (clk),
    .rstn             (rstn),
    .ls_req           (ls_req),
    .ls_we            (ls_we),
    .ls_adr           (ls_adr),
    .ls_wdata         (ls_wdata),
    .st_prv           (st_prv),
    .ls_busy          (ls_busy),
    .ls_done          (ls_done),
    .ls_err           (ls_err),
    .ls_rdata         (ls_rdata),
    .biu_stb          (ld_stb),
    .biu_stb_ack      (ld_stb_ack),
    .biu_adri         (ld_adr),
    .biu_we           (ld_we),
    .biu_di           (ld_dat_w),
    .biu_is_cacheable (),
    .biu_prv          (ld_prv),
    .biu_do           (ld_dat_r),
    .biu_ack          (ld_ack),
    .biu_err          (ld_err)
  );

  // Word-only single reads and writes, all byte lanes on
  biu_wb_arbiter #(
    .XLEN (XLEN),
    .PLEN (PLEN)
  ) u_arbiter (
    .clk        (clk),
    .rstn       (rstn),
    .if_stb     (fe_stb),
    .if_adr     (fe_adr),
    .if_we      (1'b0),
    .if_dat_w   ('0),
    .if_sel     ('1),
    .if_size    (WORD),
    .if_type    (SINGLE),
    .if_prv     (fe_prv),
    .if_stb_ack (fe_stb_ack),
    .if_ack     (fe_ack),
    .if_err     (fe_err),
    .if_dat_r   (fe_dat_r),
    .if_adr_r   (fe_adr_r),
    .ls_stb     (ld_stb),
    .ls_adr     (ld_adr),
    .ls_we      (ld_we),
    .ls_dat_w   (ld_dat_w),
    .ls_sel     ('1),
    .ls_size    (WORD),
    .ls_type    (SINGLE),
    .ls_prv     (ld_prv),
    .ls_stb_ack (ld_stb_ack),
    .ls_ack     (ld_ack),
    .ls_err     (ld_err),
    .ls_dat_r   (ld_dat_r),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_o   (wb_dat_o),
    .wb_sel     (wb_sel),
    .wb_dat_i   (wb_dat_i),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .io_access  (io_access),
    .bus_prv    (bus_prv)
  );

endmodule

`default_nettype wire
